/* project.f */
source/glay_config_pkg.sv
source/glay_mem_pkg.sv
source/cache_request_if.sv
source/response_fifo.sv
source/cache_request_arbiter.sv
source/cache_memory.sv
source/cache_generator_response.sv
source/glay_cache_top.sv
testbench/tb_glay_cache.sv

/* Bender.yml */
package:
  name: glay_cache

sources:
  # Packages first, then the interface and the RTL
  - files:
      - source/glay_config_pkg.sv
      - source/glay_mem_pkg.sv
      - source/cache_request_if.sv
      - source/response_fifo.sv
      - source/cache_request_arbiter.sv
      - source/cache_memory.sv
      - source/cache_generator_response.sv
      - source/glay_cache_top.sv
  # Testbench
  - target: test
    files:
      - testbench/tb_glay_cache.sv

/* testbench/tb_glay_cache.sv */
`timescale 1ns/1ps

module tb_glay_cache
  import glay_config_pkg::*;
  import glay_mem_pkg::*;
();

  // -------------------------------------------------------------------------
  // Run length and timeout
  // -------------------------------------------------------------------------
  localparam int reset_cycles  = 3;
  localparam int stall_reads   = 24;
  localparam int stall_hold    = 100;
  localparam int stall_window  = 20;
  localparam int random_ops    = 200;
  // Write and read-back, contention pairs, broadcast and drop, stall, random
  localparam int total_ops     = 16 + 32 + 2 + stall_reads + random_ops;
  localparam int timeout_limit = total_ops * (mem_latency + 8) + stall_hold +
                                 reset_cycles + fifo_reset_cycles + 2;
  localparam int half_depth    = mem_depth / num_requestors;
  // Longest wait for the last responses of one test
  localparam int drain_limit   = fifo_depth * 4;

  // Modes of the resp_ready driver
  localparam int ready_on     = 0;
  localparam int ready_low    = 1;
  localparam int ready_random = 2;

  // DUT ports
  logic                      ap_clk;
  logic                      areset_control;
  logic [num_requestors-1:0] req_valid;
  cmd_t                      req_cmd        [num_requestors];
  logic [addr_width-1:0]     req_address    [num_requestors];
  logic [data_width-1:0]     req_data       [num_requestors];
  logic [num_requestors-1:0] req_route_mask [num_requestors];
  logic [num_requestors-1:0] req_busy;
  logic [num_requestors-1:0] resp_valid;
  logic [data_width-1:0]     resp_data      [num_requestors];
  logic [addr_width-1:0]     resp_address   [num_requestors];
  logic                      resp_ready;
  logic                      setup_busy;

  // Reference state
  logic [data_width-1:0] ref_mem [mem_depth];
  bit                    written [mem_depth];
  response_t             exp_q   [num_requestors][$];

  string test_name = "setup";
  int    ready_mode = ready_on;
  int    cycle_count = 0;
  int    data_errors = 0;
  int    address_errors = 0;
  int    route_errors = 0;
  int    other_errors = 0;

  glay_cache_top UUT (.*);

  // Free running 20 ns clock
  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  // -------------------------------------------------------------------------
  // Reference model
  // -------------------------------------------------------------------------
  // Response the memory must return for a read issued now
  function automatic response_t expected_response(input int who,
                                                  input logic [addr_width-1:0] addr,
                                                  input logic [num_requestors-1:0] mask);
    response_t rsp;
    rsp.route.packet_source = mask;
    rsp.route.requestor_id  = id_width'(who);
    rsp.address             = addr;
    rsp.data                = ref_mem[addr];
    return rsp;
  endfunction

  function automatic logic [num_requestors-1:0] mask_of(input int who);
    return num_requestors'(1) << who;
  endfunction

  // Per requestor window for the contention and stall tests
  function automatic logic [addr_width-1:0] region_addr(input int who, input int offset);
    return addr_width'(who * half_depth + 256 + offset);
  endfunction

  function automatic int outstanding();
    int total;
    total = 0;
    for (int i = 0; i < num_requestors; i++) begin
      total += exp_q[i].size();
    end
    return total;
  endfunction

  // -------------------------------------------------------------------------
  // Compare tasks
  // -------------------------------------------------------------------------
  task automatic check_data(input logic [data_width-1:0] expected,
                            input logic [data_width-1:0] actual);
    if (actual !== expected) begin
      $display("error %s: data expected %h actual %h", test_name, expected, actual);
      data_errors++;
    end
  endtask

  task automatic check_address(input logic [addr_width-1:0] expected,
                               input logic [addr_width-1:0] actual);
    if (actual !== expected) begin
      $display("error %s: address expected %h actual %h", test_name, expected, actual);
      address_errors++;
    end
  endtask

  task automatic check_route(input route_t expected, input route_t actual);
    if (actual !== expected) begin
      $display("error %s: route expected %h actual %h", test_name, expected, actual);
      route_errors++;
    end
  endtask

  // -------------------------------------------------------------------------
  // Stimulus tasks start and end on a falling edge
  // -------------------------------------------------------------------------
  task automatic wait_idle(input logic [num_requestors-1:0] which);
    while ((req_busy & which) != '0) @(negedge ap_clk);
  endtask

  // Present one command and record what it should produce
  task automatic drive(input int who, input cmd_t cmd, input logic [addr_width-1:0] addr,
                       input logic [data_width-1:0] data,
                       input logic [num_requestors-1:0] mask);
    response_t exp_rsp;
    req_cmd[who]        = cmd;
    req_address[who]    = addr;
    req_data[who]       = data;
    req_route_mask[who] = mask;
    req_valid[who]      = 1'b1;
    if (cmd == cmd_write) begin
      ref_mem[addr] = data;
      written[addr] = 1'b1;
    end else begin
      exp_rsp = expected_response(who, addr, mask);
      // One copy per channel named in the mask
      for (int j = 0; j < num_requestors; j++) begin
        if (mask[j]) exp_q[j].push_back(exp_rsp);
      end
    end
  endtask

  task automatic send(input int who, input cmd_t cmd, input logic [addr_width-1:0] addr,
                      input logic [data_width-1:0] data,
                      input logic [num_requestors-1:0] mask);
    wait_idle(mask_of(who));
    drive(who, cmd, addr, data, mask);
    @(negedge ap_clk);
    req_valid[who] = 1'b0;
  endtask

  // Wait for the responses and then a few quiet cycles for duplicates
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (outstanding() != 0 && waited < drain_limit) begin
      @(negedge ap_clk);
      waited++;
    end
    if (outstanding() != 0) begin
      $display("%s: %0d expected responses never arrived", test_name, outstanding());
      other_errors++;
    end
    repeat (mem_latency + 6) @(negedge ap_clk);
  endtask

  // -------------------------------------------------------------------------
  // Response monitor
  // -------------------------------------------------------------------------
  initial begin : response_monitor
    response_t exp_rsp;
    forever begin
      @(negedge ap_clk);
      if (setup_busy === 1'b1 && resp_valid != '0) begin
        $display("%s: a response was delivered while setup_busy was high", test_name);
        other_errors++;
      end
      for (int i = 0; i < num_requestors; i++) begin
        if (resp_valid[i] === 1'b1) begin
          if (exp_q[i].size() == 0) begin
            $display("%s: requestor %0d got a response it never asked for", test_name, i);
            other_errors++;
          end else begin
            exp_rsp = exp_q[i].pop_front();
            check_data(exp_rsp.data, resp_data[i]);
            check_address(exp_rsp.address, resp_address[i]);
            check_route(exp_rsp.route, UUT.resp_packet.route);
            // Broadcast copies land in one cycle
            if ((resp_valid & exp_rsp.route.packet_source) != exp_rsp.route.packet_source) begin
              $display("%s: broadcast reached only some channels in one cycle", test_name);
              other_errors++;
            end
          end
        end
      end
    end
  end

  // Owns resp_ready
  initial begin : ready_driver
    resp_ready = 1'b1;
    forever begin
      @(negedge ap_clk);
      case (ready_mode)
        ready_low:    resp_ready = 1'b0;
        ready_random: resp_ready = 1'($urandom % 2);
        default:      resp_ready = 1'b1;
      endcase
    end
  end

  // Cycle limit
  initial begin : watchdog
    while (cycle_count < timeout_limit) begin
      @(posedge ap_clk);
      cycle_count++;
    end
    $display("timeout: no finish after %0d cycles in test %s", timeout_limit, test_name);
    $display("errors: data %0d, address %0d, route %0d, other %0d",
             data_errors, address_errors, route_errors, other_errors);
    $display("** FAIL **");
    $finish;
  end

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------
  initial begin : main_sequence
    int                    who;
    int                    setup_cycles;
    logic [addr_width-1:0] addr;
    void'($urandom(32'h8cc2beb3));
    areset_control = 1'b1;
    req_valid      = '0;
    for (int i = 0; i < num_requestors; i++) begin
      req_cmd[i]        = cmd_read;
      req_address[i]    = '0;
      req_data[i]       = '0;
      req_route_mask[i] = '0;
    end

    // Setup flag through reset and after
    repeat (reset_cycles) begin
      @(negedge ap_clk);
      if (setup_busy !== 1'b1) begin
        $display("setup: setup_busy is not high during reset");
        other_errors++;
      end
    end
    areset_control = 1'b0;
    @(negedge ap_clk);
    setup_cycles = 0;
    while (setup_busy !== 1'b0 && setup_cycles < fifo_reset_cycles + 2) begin
      @(negedge ap_clk);
      setup_cycles++;
    end
    if (setup_busy !== 1'b0) begin
      $display("setup: setup_busy still high %0d cycles after reset", setup_cycles);
      other_errors++;
    end
    while (setup_busy !== 1'b0) @(negedge ap_clk);

    // Requestor 0 writes then reads back
    test_name = "write_read";
    for (int k = 0; k < 8; k++) send(0, cmd_write, addr_width'(64 + k), $urandom, '0);
    for (int k = 0; k < 8; k++) send(0, cmd_read, addr_width'(64 + k), '0, mask_of(0));
    wait_drain();

    // Both channels strobe in the same cycle
    test_name = "contention";
    for (int r = 0; r < 16; r++) begin
      wait_idle('1);
      for (int i = 0; i < num_requestors; i++) begin
        addr = region_addr(i, r % 8);
        if (r < 8) drive(i, cmd_write, addr, $urandom, '0);
        else drive(i, cmd_read, addr, '0, mask_of(i));
      end
      @(negedge ap_clk);
      req_valid = '0;
    end
    wait_drain();

    test_name = "broadcast";
    send(0, cmd_read, addr_width'(64), '0, {num_requestors{1'b1}});
    wait_drain();
    // Nothing may leave the memory for an empty mask
    test_name = "drop";
    send(1, cmd_read, region_addr(1, 0), '0, '0);
    repeat (mem_latency + 8) begin
      @(negedge ap_clk);
      if (UUT.mem_rsp_valid === 1'b1) begin
        $display("drop: a read with an empty route mask produced a response");
        other_errors++;
      end
    end
    wait_drain();

    // FIFO fills with resp_ready low
    test_name = "back_pressure";
    ready_mode = ready_low;
    fork
      begin
        for (int n = 0; n < stall_reads; n++) begin
          send(n % 2, cmd_read, region_addr(n % 2, (n / 2) % 8), '0, mask_of(n % 2));
        end
      end
      begin
        repeat (stall_hold - stall_window) @(negedge ap_clk);
        repeat (stall_window) begin
          @(negedge ap_clk);
          if (req_busy == '0) begin
            $display("back_pressure: no requestor held busy while responses were stalled");
            other_errors++;
          end
        end
        ready_mode = ready_on;
      end
    join
    wait_drain();

    // Mixed traffic with each requestor in its own half
    test_name = "random";
    ready_mode = ready_random;
    for (int n = 0; n < random_ops; n++) begin
      who  = int'($urandom % num_requestors);
      addr = addr_width'(who * half_depth + 128 + int'($urandom % 64));
      if (($urandom % 2) == 1 || !written[addr]) begin
        send(who, cmd_write, addr, $urandom, '0);
      end else begin
        send(who, cmd_read, addr, '0, mask_of(who));
      end
    end
    ready_mode = ready_on;
    wait_drain();

    $display("errors: data %0d, address %0d, route %0d, other %0d",
             data_errors, address_errors, route_errors, other_errors);
    if (data_errors + address_errors + route_errors + other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_glay_cache

/* source/glay_cache_top.sv */
`timescale 1ns/1ps

module glay_cache_top
  import glay_config_pkg::*;
  import glay_mem_pkg::*;
(
  input  logic                      ap_clk,
  input  logic                      areset_control,
  // Requestor command side
  input  logic [num_requestors-1:0] req_valid,
  input  cmd_t                      req_cmd        [num_requestors],
  input  logic [addr_width-1:0]     req_address    [num_requestors],
  input  logic [data_width-1:0]     req_data       [num_requestors],
  input  logic [num_requestors-1:0] req_route_mask [num_requestors],
  output logic [num_requestors-1:0] req_busy,
  // Requestor response side
  output logic [num_requestors-1:0] resp_valid,
  output logic [data_width-1:0]     resp_data      [num_requestors],
  output logic [addr_width-1:0]     resp_address   [num_requestors],
  input  logic                      resp_ready,
  output logic                      setup_busy
);

  request_t  req_packet [num_requestors];
  logic      mem_rsp_valid;
  response_t mem_rsp;
  logic      fifo_prog_full;
  response_t resp_packet;

  // Port groups to packets, the channel index is the requestor id
  for (genvar i = 0; i < num_requestors; i++) begin : g_requestor
    assign req_packet[i] = '{
      cmd:     req_cmd[i],
      address: req_address[i],
      data:    req_data[i],
      route:   '{packet_source: req_route_mask[i], requestor_id: id_width'(i)}
    };
    // Every channel sees the shared payload
    assign resp_data[i]    = resp_packet.data;
    assign resp_address[i] = resp_packet.address;
  end

  cache_request_if req_bus ();

  cache_request_arbiter u_arbiter (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .req_valid      (req_valid),
    .req            (req_packet),
    .req_busy       (req_busy),
    .fifo_prog_full (fifo_prog_full),
    .mem            (req_bus.arbiter)
  );

  cache_memory u_memory (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .mem            (req_bus.memory),
    .rsp_valid      (mem_rsp_valid),
    .rsp            (mem_rsp)
  );

  cache_generator_response u_response (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .response_in_valid  (mem_rsp_valid),
    .response_in        (mem_rsp),
    .rd_en              (resp_ready),
    .prog_full          (fifo_prog_full),
    .response_out_valid (resp_valid),
    .response_out       (resp_packet),
    .fifo_setup_signal  (setup_busy)
  );

endmodule : glay_cache_top

/* source/cache_generator_response.sv */
`timescale 1ns/1ps

module cache_generator_response
  import glay_config_pkg::*;
  import glay_mem_pkg::*;
(
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic                      response_in_valid,
  input  response_t                 response_in,
  input  logic                      rd_en,
  output logic                      prog_full,
  output logic [num_requestors-1:0] response_out_valid,
  output response_t                 response_out,
  output logic                      fifo_setup_signal
);

  // -------------------------------------------------------------------------
  // Local reset copies and input stage
  // -------------------------------------------------------------------------
  logic      reset_ctrl_q;
  logic      reset_fifo_q;
  logic      response_in_valid_q;
  response_t response_in_q;

  // FIFO side
  response_t fifo_dout;
  logic      fifo_wr_en;
  logic      fifo_rd_en;
  logic      fifo_empty;
  logic      fifo_valid;
  logic      fifo_wr_rst_busy;
  logic      fifo_rd_rst_busy;
  logic      fifo_setup_int;

  // Separate copies for control logic and the FIFO
  always_ff @(posedge ap_clk) begin
    reset_ctrl_q <= areset_control;
    reset_fifo_q <= areset_control;
  end

  always_ff @(posedge ap_clk) begin
    if (reset_ctrl_q) begin
      response_in_valid_q <= 1'b0;
    end else begin
      response_in_valid_q <= response_in_valid;
    end
  end

  // Payload, no reset
  always_ff @(posedge ap_clk) begin
    response_in_q <= response_in;
  end

  // -------------------------------------------------------------------------
  // FIFO control
  // -------------------------------------------------------------------------
  // Push
  assign fifo_wr_en = response_in_valid_q;
  // Pop
  assign fifo_rd_en = ~fifo_empty & rd_en;
  // Setup while either side is busy
  assign fifo_setup_int = fifo_wr_rst_busy | fifo_rd_rst_busy;

  always_ff @(posedge ap_clk) begin
    if (areset_control || reset_ctrl_q) begin
      fifo_setup_signal <= 1'b1;
    end else begin
      fifo_setup_signal <= fifo_setup_int;
    end
  end

  response_fifo u_response_fifo (
    .ap_clk      (ap_clk),
    .srst        (reset_fifo_q),
    .din         (response_in_q),
    .wr_en       (fifo_wr_en),
    .rd_en       (fifo_rd_en),
    .dout        (fifo_dout),
    // Fill is bounded by prog_full back-pressure
    .full        (),
    .empty       (fifo_empty),
    .valid       (fifo_valid),
    .prog_full   (prog_full),
    .wr_rst_busy (fifo_wr_rst_busy),
    .rd_rst_busy (fifo_rd_rst_busy)
  );

  // -------------------------------------------------------------------------
  // Route demux
  // -------------------------------------------------------------------------
  // One strobe per mask bit, several may fire together
  always_ff @(posedge ap_clk) begin
    if (reset_ctrl_q) begin
      response_out_valid <= '0;
    end else begin
      for (int i = 0; i < num_requestors; i++) begin
        response_out_valid[i] <= fifo_valid & fifo_dout.route.packet_source[i];
      end
    end
  end

  // Shared payload for all requestors
  always_ff @(posedge ap_clk) begin
    response_out <= fifo_dout;
  end

  // No delivery while the FIFO is still in setup
  assert property (@(posedge ap_clk) disable iff (areset_control)
    fifo_setup_signal |-> (response_out_valid == '0));

endmodule : cache_generator_response

/* source/cache_memory.sv */
`timescale 1ns/1ps

module cache_memory
  import glay_config_pkg::*;
  import glay_mem_pkg::*;
(
  input  logic            ap_clk,
  input  logic            areset_control,
  cache_request_if.memory mem,
  output logic            rsp_valid,
  output response_t       rsp
);

  // -------------------------------------------------------------------------
  // Storage and read pipeline
  // -------------------------------------------------------------------------
  logic [data_width-1:0]  ram [mem_depth];
  logic [mem_latency-1:0] pipe_valid;
  response_t              pipe_rsp [mem_latency];
  logic                   rd_fire;

  // Reads with an empty mask still run but raise no response
  assign rd_fire = mem.valid & (mem.cmd == cmd_read) & (|mem.route.packet_source);

  // Write port, plus the stage 0 read
  always_ff @(posedge ap_clk) begin
    if (mem.valid && (mem.cmd == cmd_write)) begin
      ram[mem.address] <= mem.data;
    end
    pipe_rsp[0].data    <= ram[mem.address];
    pipe_rsp[0].address <= mem.address;
    pipe_rsp[0].route   <= mem.route;
    // Later stages carry the whole packet
    for (int s = 1; s < mem_latency; s++) begin
      pipe_rsp[s] <= pipe_rsp[s-1];
    end
  end

  // Strobe travels with the data, one read per cycle
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid[0] <= rd_fire;
      for (int s = 1; s < mem_latency; s++) begin
        pipe_valid[s] <= pipe_valid[s-1];
      end
    end
  end

  assign rsp_valid = pipe_valid[mem_latency-1];
  assign rsp       = pipe_rsp[mem_latency-1];

  // Address stays inside the array
  assert property (@(posedge ap_clk) disable iff (areset_control)
    mem.valid |-> (int'(mem.address) < mem_depth));

endmodule : cache_memory

/* source/cache_request_arbiter.sv */
`timescale 1ns/1ps

module cache_request_arbiter
  import glay_config_pkg::*;
  import glay_mem_pkg::*;
(
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic [num_requestors-1:0] req_valid,
  input  request_t                  req [num_requestors],
  output logic [num_requestors-1:0] req_busy,
  input  logic                      fifo_prog_full,
  cache_request_if.arbiter          mem
);

  // -------------------------------------------------------------------------
  // Pending slots
  // -------------------------------------------------------------------------
  logic [num_requestors-1:0] pending_valid;
  request_t                  pending_req [num_requestors];
  logic [num_requestors-1:0] eligible;
  logic [id_width-1:0]       rr_ptr;
  logic [id_width-1:0]       grant_idx;
  logic [id_width-1:0]       next_ptr;
  logic                      grant_found;
  int unsigned               cand;

  // Busy as long as the slot holds a request
  assign req_busy = pending_valid;

  // Fill on strobe, clear when admitted
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pending_valid <= '0;
    end else begin
      for (int i = 0; i < num_requestors; i++) begin
        if (req_valid[i]) begin
          pending_valid[i] <= 1'b1;
        end else if (grant_found && (grant_idx == id_width'(i))) begin
          pending_valid[i] <= 1'b0;
        end
      end
    end
  end

  // Slot payload
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < num_requestors; i++) begin
      if (req_valid[i]) begin
        pending_req[i] <= req[i];
      end
    end
  end

  // -------------------------------------------------------------------------
  // Round-robin pick
  // -------------------------------------------------------------------------
  // Reads wait while the response FIFO is near full, writes go through
  always_comb begin
    for (int i = 0; i < num_requestors; i++) begin
      eligible[i] = pending_valid[i] &
                    ((pending_req[i].cmd == cmd_write) | ~fifo_prog_full);
    end
  end

  // First eligible slot at or after the pointer
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = '0;
    cand        = 0;
    for (int k = 0; k < num_requestors; k++) begin
      cand = (int'(rr_ptr) + k) % num_requestors;
      if (!grant_found && eligible[cand]) begin
        grant_found = 1'b1;
        grant_idx   = id_width'(cand);
      end
    end
  end

  // Pointer moves one past the winner
  assign next_ptr = (grant_idx == id_width'(num_requestors - 1)) ? '0 : grant_idx + 1'b1;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      mem.valid <= 1'b0;
      rr_ptr    <= '0;
    end else begin
      mem.valid <= grant_found;
      if (grant_found) begin
        rr_ptr <= next_ptr;
      end
    end
  end

  // Registered copy of the winning slot
  always_ff @(posedge ap_clk) begin
    mem.cmd     <= pending_req[grant_idx].cmd;
    mem.address <= pending_req[grant_idx].address;
    mem.data    <= pending_req[grant_idx].data;
    mem.route   <= pending_req[grant_idx].route;
  end

  // -------------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------------
  // Each strobe on the bus retires exactly one slot
  assert property (@(posedge ap_clk) disable iff (areset_control)
    $countones($past(pending_valid) & ~pending_valid) == int'(mem.valid));

  // Requestors respect req_busy
  assert property (@(posedge ap_clk) disable iff (areset_control)
    (req_valid & req_busy) == '0);

endmodule : cache_request_arbiter

/* source/response_fifo.sv */
`timescale 1ns/1ps

module response_fifo
  import glay_config_pkg::*;
  import glay_mem_pkg::*;
(
  input  logic      ap_clk,
  input  logic      srst,
  input  response_t din,
  input  logic      wr_en,
  input  logic      rd_en,
  output response_t dout,
  output logic      full,
  output logic      empty,
  output logic      valid,
  output logic      prog_full,
  output logic      wr_rst_busy,
  output logic      rd_rst_busy
);

  // -------------------------------------------------------------------------
  // Circular buffer state
  // -------------------------------------------------------------------------
  logic [response_width-1:0] storage [fifo_depth];
  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  logic [fifo_ptr_width:0]   count;
  logic [rst_cnt_width-1:0]  rst_cnt;
  logic                      wr_accept;
  logic                      rd_accept;

  // Flags from the fill count
  assign full      = (count == (fifo_ptr_width + 1)'(fifo_depth));
  assign empty     = (count == '0);
  assign prog_full = (count >= (fifo_ptr_width + 1)'(prog_thresh));

  // Nothing moves while either side is still coming out of reset
  assign wr_accept = wr_en & ~full & ~wr_rst_busy;
  assign rd_accept = rd_en & ~empty & ~rd_rst_busy;

  // -------------------------------------------------------------------------
  // Reset-busy window
  // -------------------------------------------------------------------------
  // Read side trails the write side by one cycle
  always_ff @(posedge ap_clk) begin
    if (srst) begin
      rst_cnt     <= rst_cnt_width'(fifo_reset_cycles);
      rd_rst_busy <= 1'b1;
    end else begin
      if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - 1'b1;
      end
      rd_rst_busy <= wr_rst_busy;
    end
  end

  assign wr_rst_busy = (rst_cnt != '0);

  // -------------------------------------------------------------------------
  // Pointers and count
  // -------------------------------------------------------------------------
  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge ap_clk) begin
    if (srst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      if (wr_accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_accept) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_accept, rd_accept})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Registered read, valid one cycle after rd_en
      valid <= rd_accept;
    end
  end

  // Entry storage and output register
  always_ff @(posedge ap_clk) begin
    if (wr_accept) begin
      storage[wr_ptr] <= din;
    end
    if (rd_accept) begin
      dout <= storage[rd_ptr];
    end
  end

  // Upstream must keep the fill below depth
  assert property (@(posedge ap_clk) disable iff (srst) wr_en |-> !full);

endmodule : response_fifo

/* source/cache_request_if.sv */
`timescale 1ns/1ps

interface cache_request_if
  import glay_config_pkg::*;
  import glay_mem_pkg::*;
();

  // One admitted request per strobe
  logic                  valid;
  cmd_t                  cmd;
  logic [addr_width-1:0] address;
  logic [data_width-1:0] data;
  route_t                route;

  // Arbiter side drives the admitted slot
  modport arbiter (
    output valid, cmd, address, data, route
  );

  // Memory side executes it
  modport memory (
    input valid, cmd, address, data, route
  );

endinterface : cache_request_if

/* source/glay_mem_pkg.sv */
package glay_mem_pkg;

  import glay_config_pkg::*;

  // -------------------------------------------------------------------------
  // Command encoding
  // -------------------------------------------------------------------------
  // Single bit, read is the idle encoding
  typedef enum logic {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } cmd_t;

  // -------------------------------------------------------------------------
  // Routing
  // -------------------------------------------------------------------------
  // One mask bit per requestor that receives the response
  // Id of the requestor that issued the command
  typedef struct packed {
    logic [num_requestors-1:0] packet_source;
    logic [id_width-1:0]       requestor_id;
  } route_t;

  // -------------------------------------------------------------------------
  // Request packet
  // -------------------------------------------------------------------------
  // Data is ignored on reads
  typedef struct packed {
    cmd_t                  cmd;
    logic [addr_width-1:0] address;
    logic [data_width-1:0] data;
    route_t                route;
  } request_t;

  // -------------------------------------------------------------------------
  // Response packet
  // -------------------------------------------------------------------------
  // Read data with the route and address it was issued with
  typedef struct packed {
    route_t                route;
    logic [addr_width-1:0] address;
    logic [data_width-1:0] data;
  } response_t;

  // Width of one FIFO entry
  localparam int response_width = $bits(response_t);

endpackage : glay_mem_pkg

/* source/glay_config_pkg.sv */
package glay_config_pkg;

  // -------------------------------------------------------------------------
  // Overlay sizing
  // -------------------------------------------------------------------------
  // Requestor channels sharing the cache
  localparam int num_requestors = 2;
  // Requestor id field, at least one bit
  localparam int id_width = (num_requestors > 1) ? $clog2(num_requestors) : 1;

  // Cache word address and data
  localparam int addr_width = 10;
  localparam int data_width = 32;
  localparam int mem_depth = 1024;
  // Read pipeline depth of the cache RAM
  localparam int mem_latency = 2;

  // -------------------------------------------------------------------------
  // Response FIFO
  // -------------------------------------------------------------------------
  localparam int fifo_depth = 32;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  // Fill level that raises prog_full
  localparam int prog_thresh = 16;
  // Reset-busy window after srst drops
  localparam int fifo_reset_cycles = 4;
  localparam int rst_cnt_width = $clog2(fifo_reset_cycles + 1);

endpackage : glay_config_pkg
